// File: verilog.f
rtl/mul_pkg.sv
rtl/mul_stage.sv
rtl/mul_pipe.sv
rtl/mul_writeback.sv
rtl/mul_unit.sv
testbench/tb_mul_unit.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the mul_unit testbench

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary -j 0 --top-module tb_mul_unit -f verilog.f -Mdir obj_dir -o tb_mul_unit
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_mul_unit > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "TESTS FAILED" "$log"; then
   echo "simulation reported a failure, see $log"
   exit 1
fi

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

echo "simulation finished without failures, log in $log"
exit 0

// File: testbench/tb_mul_unit.sv
`timescale 1ns/1ps

module tb_mul_unit;

   logic              clock;
   logic              reset;
   logic              issue_valid;
   mul_pkg::mul_op_t  issue_op;
   mul_pkg::xlen_t    rs1_data;
   mul_pkg::xlen_t    rs2_data;
   mul_pkg::rob_tag_t issue_rob_tag;
   mul_pkg::prf_tag_t issue_prd;
   logic              flush_valid;
   mul_pkg::rob_tag_t flush_rob_tag;
   logic              wb_valid;
   mul_pkg::xlen_t    wb_data;
   mul_pkg::rob_tag_t wb_rob_tag;
   mul_pkg::prf_tag_t wb_prd;

   // stimulus table with one row per cycle
   logic              row_rst   [$];
   logic              row_issue [$];
   logic              row_rand  [$];
   mul_pkg::mul_op_t  row_op    [$];
   mul_pkg::xlen_t    row_rs1   [$];
   mul_pkg::xlen_t    row_rs2   [$];
   mul_pkg::rob_tag_t row_tag   [$];
   mul_pkg::prf_tag_t row_prd   [$];
   logic              row_flush [$];
   mul_pkg::rob_tag_t row_ftag  [$];

   // model pipeline from the op just issued (slot 0) to the one due on the bus
   logic              exp_valid [0:mul_pkg::MUL_STAGES];
   mul_pkg::xlen_t    exp_data  [0:mul_pkg::MUL_STAGES];
   mul_pkg::rob_tag_t exp_tag   [0:mul_pkg::MUL_STAGES];
   mul_pkg::prf_tag_t exp_prd   [0:mul_pkg::MUL_STAGES];

   logic [31:0]       rand_state;
   int                cycle_count = 0;
   int                cycle_limit = 0;

   mul_unit u_mul_unit (
      .clock         (clock),
      .reset         (reset),
      .issue_valid   (issue_valid),
      .issue_op      (issue_op),
      .rs1_data      (rs1_data),
      .rs2_data      (rs2_data),
      .issue_rob_tag (issue_rob_tag),
      .issue_prd     (issue_prd),
      .flush_valid   (flush_valid),
      .flush_rob_tag (flush_rob_tag),
      .wb_valid      (wb_valid),
      .wb_data       (wb_data),
      .wb_rob_tag    (wb_rob_tag),
      .wb_prd        (wb_prd)
   );

   initial clock = 1'b0;
   always #20 clock = ~clock;

   always @(posedge clock) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles, the stimulus table never finished", cycle_count);
         $display("TESTS FAILED");
         $fatal(1, "timeout");
      end
   end

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // full product by the op's signedness and the half it asks for
   function automatic mul_pkg::xlen_t model_result(input mul_pkg::mul_op_t op,
                                                   input mul_pkg::xlen_t a,
                                                   input mul_pkg::xlen_t b);
      logic [63:0] product;
      case (op)
         mul_pkg::MUL_OP_MULH:   product = 64'($signed(a)) * 64'($signed(b));
         mul_pkg::MUL_OP_MULHSU: product = 64'($signed(a)) * {32'h0, b};
         default:                product = {32'h0, a} * {32'h0, b};
      endcase
      if (op == mul_pkg::MUL_OP_MUL) begin
         return product[31:0];
      end
      return product[63:32];
   endfunction

   function automatic logic flush_kills(input mul_pkg::rob_tag_t tag,
                                        input mul_pkg::rob_tag_t ftag);
      logic same_wrap;
      logic below;
      same_wrap = tag[mul_pkg::ROB_IDX_BITS] == ftag[mul_pkg::ROB_IDX_BITS];
      below     = tag[mul_pkg::ROB_IDX_BITS-1:0] < ftag[mul_pkg::ROB_IDX_BITS-1:0];
      return same_wrap ? below : !below;  // inverted across a wrap
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("TESTS FAILED");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         $display("** Error: %s expected 0x%h actual 0x%h", name, expected, actual);
         $display("TESTS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic add_row(input logic rst, input logic iv, input logic rnd,
                          input mul_pkg::mul_op_t op, input mul_pkg::xlen_t rs1,
                          input mul_pkg::xlen_t rs2, input mul_pkg::rob_tag_t tag,
                          input mul_pkg::prf_tag_t prd, input logic fv,
                          input mul_pkg::rob_tag_t ftag);
      row_rst.push_back(rst);
      row_issue.push_back(iv);
      row_rand.push_back(rnd);
      row_op.push_back(op);
      row_rs1.push_back(rs1);
      row_rs2.push_back(rs2);
      row_tag.push_back(tag);
      row_prd.push_back(prd);
      row_flush.push_back(fv);
      row_ftag.push_back(ftag);
   endtask

   task automatic add_idle(input int n);
      for (int i = 0; i < n; i++) begin
         add_row(1'b0, 1'b0, 1'b0, 2'd0, 32'h0, 32'h0, 5'h00, 6'h00, 1'b0, 5'h00);
      end
   endtask

   // ops 0 to 3 are mul mulh mulhsu mulhu
   // tag bit 4 is the wrap bit
   task automatic build_table();
      // rst   iv    rnd   op    rs1           rs2           tag    prd    fv    ftag
      add_row(1'b0, 1'b1, 1'b0, 2'd0, 32'h00000000, 32'h12345678, 5'h00, 6'h01, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b0, 2'd0, 32'h00000001, 32'hffffffff, 5'h01, 6'h02, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b0, 2'd0, 32'hffffffff, 32'hffffffff, 5'h02, 6'h03, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b0, 2'd0, 32'h80000000, 32'h80000000, 5'h03, 6'h04, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b0, 2'd0, 32'h80000000, 32'hffffffff, 5'h04, 6'h05, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd0, 32'h00000000, 32'h00000000, 5'h05, 6'h06, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd0, 32'h00000000, 32'h00000000, 5'h06, 6'h07, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd0, 32'h00000000, 32'h00000000, 5'h07, 6'h08, 1'b0, 5'h00);
      // high halves with negative operands
      add_row(1'b0, 1'b1, 1'b0, 2'd1, 32'hffffffff, 32'h00000002, 5'h08, 6'h09, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b0, 2'd1, 32'h80000000, 32'h80000000, 5'h09, 6'h0a, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b0, 2'd2, 32'hffffffff, 32'hffffffff, 5'h0a, 6'h0b, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b0, 2'd2, 32'h80000000, 32'h00000003, 5'h0b, 6'h0c, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b0, 2'd3, 32'hffffffff, 32'hffffffff, 5'h0c, 6'h0d, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b0, 2'd3, 32'h80000000, 32'h80000000, 5'h0d, 6'h0e, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd1, 32'h00000000, 32'h00000000, 5'h0e, 6'h0f, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd2, 32'h00000000, 32'h00000000, 5'h0f, 6'h10, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd3, 32'h00000000, 32'h00000000, 5'h10, 6'h11, 1'b0, 5'h00);
      add_idle(3);  // gap in the issue stream
      add_row(1'b0, 1'b1, 1'b1, 2'd0, 32'h00000000, 32'h00000000, 5'h11, 6'h12, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd1, 32'h00000000, 32'h00000000, 5'h12, 6'h13, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd3, 32'h00000000, 32'h00000000, 5'h13, 6'h14, 1'b0, 5'h00);
      add_idle(6);
      // same wrap flush at index 5
      // tag 01 is in writeback and tag 02 in the last stage during the flush
      add_row(1'b0, 1'b1, 1'b1, 2'd0, 32'h00000000, 32'h00000000, 5'h01, 6'h20, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd1, 32'h00000000, 32'h00000000, 5'h02, 6'h21, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd2, 32'h00000000, 32'h00000000, 5'h06, 6'h22, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd3, 32'h00000000, 32'h00000000, 5'h03, 6'h23, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd0, 32'h00000000, 32'h00000000, 5'h04, 6'h24, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd0, 32'h00000000, 32'h00000000, 5'h08, 6'h25, 1'b1, 5'h05);
      add_idle(5);
      // two cycle flush against mixed wrap bits
      add_row(1'b0, 1'b1, 1'b1, 2'd0, 32'h00000000, 32'h00000000, 5'h12, 6'h30, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd1, 32'h00000000, 32'h00000000, 5'h19, 6'h31, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd2, 32'h00000000, 32'h00000000, 5'h0c, 6'h32, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd3, 32'h00000000, 32'h00000000, 5'h14, 6'h33, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd0, 32'h00000000, 32'h00000000, 5'h03, 6'h34, 1'b1, 5'h06);
      add_row(1'b0, 1'b1, 1'b1, 2'd0, 32'h00000000, 32'h00000000, 5'h17, 6'h35, 1'b1, 5'h06);
      add_idle(5);
      // reset with ops in flight
      add_row(1'b0, 1'b1, 1'b1, 2'd0, 32'h00000000, 32'h00000000, 5'h01, 6'h38, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd1, 32'h00000000, 32'h00000000, 5'h02, 6'h39, 1'b0, 5'h00);
      add_row(1'b0, 1'b1, 1'b1, 2'd3, 32'h00000000, 32'h00000000, 5'h03, 6'h3a, 1'b0, 5'h00);
      add_row(1'b1, 1'b1, 1'b1, 2'd0, 32'h00000000, 32'h00000000, 5'h04, 6'h3b, 1'b0, 5'h00);
      add_idle(6);
      add_row(1'b0, 1'b1, 1'b1, 2'd2, 32'h00000000, 32'h00000000, 5'h05, 6'h3c, 1'b0, 5'h00);
      add_idle(6);
   endtask

   task automatic apply_row(input int j);
      mul_pkg::xlen_t a;
      mul_pkg::xlen_t b;
      a = row_rs1[j];
      b = row_rs2[j];
      if (row_rand[j]) begin
         rand_state = next_random(rand_state);
         a          = rand_state;
         rand_state = next_random(rand_state);
         b          = rand_state;
      end
      reset         = row_rst[j];
      issue_valid   = row_issue[j];
      issue_op      = row_op[j];
      rs1_data      = a;
      rs2_data      = b;
      issue_rob_tag = row_tag[j];
      issue_prd     = row_prd[j];
      flush_valid   = row_flush[j];
      flush_rob_tag = row_ftag[j];
   endtask

   task automatic check_writeback(input int j);
      logic due;
      due = exp_valid[mul_pkg::MUL_STAGES] && !flush_valid;  // flush hides any pulse
      if (due && wb_valid !== 1'b1) begin
         stop_with_failure($sformatf(
            "row %0d: expected a writeback pulse for rob tag %h, none came",
            j, exp_tag[mul_pkg::MUL_STAGES]));
      end else if (!due && wb_valid !== 1'b0) begin
         stop_with_failure($sformatf("row %0d: writeback pulse where none was expected", j));
      end
      if (due) begin
         check_value("wb_data", 64'(exp_data[mul_pkg::MUL_STAGES]), 64'(wb_data));
         check_value("wb_rob_tag", 64'(exp_tag[mul_pkg::MUL_STAGES]), 64'(wb_rob_tag));
         check_value("wb_prd", 64'(exp_prd[mul_pkg::MUL_STAGES]), 64'(wb_prd));
      end
   endtask

   // every entry that moves at the next edge sees this cycle's flush and reset
   task automatic advance_model();
      for (int s = mul_pkg::MUL_STAGES; s > 0; s--) begin
         exp_valid[s] = exp_valid[s-1];
         exp_data[s]  = exp_data[s-1];
         exp_tag[s]   = exp_tag[s-1];
         exp_prd[s]   = exp_prd[s-1];
      end
      exp_valid[0] = issue_valid;
      exp_data[0]  = model_result(issue_op, rs1_data, rs2_data);
      exp_tag[0]   = issue_rob_tag;
      exp_prd[0]   = issue_prd;
      for (int s = 0; s <= mul_pkg::MUL_STAGES; s++) begin
         if (reset || (flush_valid && flush_kills(exp_tag[s], flush_rob_tag))) begin
            exp_valid[s] = 1'b0;
         end
      end
   endtask

   initial begin
      reset         = 1'b1;
      issue_valid   = 1'b0;
      issue_op      = mul_pkg::MUL_OP_MUL;
      rs1_data      = '0;
      rs2_data      = '0;
      issue_rob_tag = '0;
      issue_prd     = '0;
      flush_valid   = 1'b0;
      flush_rob_tag = '0;
      rand_state    = 32'h3902db16;
      for (int s = 0; s <= mul_pkg::MUL_STAGES; s++) begin
         exp_valid[s] = 1'b0;
      end
      build_table();
      cycle_limit = row_issue.size() + mul_pkg::MUL_STAGES + 1 + 20;

      repeat (3) @(posedge clock);
      for (int j = 0; j < row_issue.size(); j++) begin
         #2;
         apply_row(j);
         @(negedge clock);  // outputs settled by mid cycle
         check_writeback(j);
         advance_model();
         @(posedge clock);
      end
      $display("TESTS PASSED");
      $finish;
   end

endmodule

// File: rtl/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
   input  logic              clock,
   input  logic              reset,
   // issue
   input  logic              issue_valid,
   input  mul_pkg::mul_op_t  issue_op,
   input  mul_pkg::xlen_t    rs1_data,
   input  mul_pkg::xlen_t    rs2_data,
   input  mul_pkg::rob_tag_t issue_rob_tag,
   input  mul_pkg::prf_tag_t issue_prd,
   // branch recovery
   input  logic              flush_valid,
   input  mul_pkg::rob_tag_t flush_rob_tag,
   // common data bus
   output logic              wb_valid,
   output mul_pkg::xlen_t    wb_data,
   output mul_pkg::rob_tag_t wb_rob_tag,
   output mul_pkg::prf_tag_t wb_prd
);

   logic              pipe_valid;
   mul_pkg::dword_t   pipe_product;
   logic              pipe_high;
   mul_pkg::rob_tag_t pipe_rob_tag;
   mul_pkg::prf_tag_t pipe_prd;

   mul_pipe u_mul_pipe (
      .clock         (clock),
      .reset         (reset),
      .issue_valid   (issue_valid),
      .issue_op      (issue_op),
      .rs1_data      (rs1_data),
      .rs2_data      (rs2_data),
      .issue_rob_tag (issue_rob_tag),
      .issue_prd     (issue_prd),
      .flush_valid   (flush_valid),
      .flush_rob_tag (flush_rob_tag),
      .pipe_valid    (pipe_valid),
      .pipe_product  (pipe_product),
      .pipe_high     (pipe_high),
      .pipe_rob_tag  (pipe_rob_tag),
      .pipe_prd      (pipe_prd)
   );

   mul_writeback u_mul_writeback (
      .clock         (clock),
      .reset         (reset),
      .pipe_valid    (pipe_valid),
      .pipe_product  (pipe_product),
      .pipe_high     (pipe_high),
      .pipe_rob_tag  (pipe_rob_tag),
      .pipe_prd      (pipe_prd),
      .flush_valid   (flush_valid),
      .flush_rob_tag (flush_rob_tag),
      .wb_valid      (wb_valid),
      .wb_data       (wb_data),
      .wb_rob_tag    (wb_rob_tag),
      .wb_prd        (wb_prd)
   );

endmodule

// File: rtl/mul_writeback.sv
`timescale 1ns/1ps

module mul_writeback (
   input  logic              clock,
   input  logic              reset,
   input  logic              pipe_valid,
   input  mul_pkg::dword_t   pipe_product,
   input  logic              pipe_high,
   input  mul_pkg::rob_tag_t pipe_rob_tag,
   input  mul_pkg::prf_tag_t pipe_prd,
   input  logic              flush_valid,
   input  mul_pkg::rob_tag_t flush_rob_tag,
   output logic              wb_valid,
   output mul_pkg::xlen_t    wb_data,
   output mul_pkg::rob_tag_t wb_rob_tag,
   output mul_pkg::prf_tag_t wb_prd
);

   logic              held_q;
   mul_pkg::xlen_t    data_q;
   mul_pkg::rob_tag_t rob_tag_q;
   mul_pkg::prf_tag_t prd_q;
   logic              kill_in;

   // last stage entry dies on its way in
   assign kill_in = flush_valid & mul_pkg::rob_killed(pipe_rob_tag, flush_rob_tag);

   always_ff @(posedge clock) begin
      if (pipe_valid) begin
         data_q    <= pipe_high ? pipe_product[2*mul_pkg::XLEN-1:mul_pkg::XLEN]
                                : pipe_product[mul_pkg::XLEN-1:0];
         rob_tag_q <= pipe_rob_tag;
         prd_q     <= pipe_prd;
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         held_q <= 1'b0;
      end else begin
         held_q <= pipe_valid & ~kill_in;
      end
   end

   // no pulse at all while a flush is up
   assign wb_valid   = held_q & ~flush_valid;
   assign wb_data    = data_q;
   assign wb_rob_tag = rob_tag_q;
   assign wb_prd     = prd_q;

endmodule

// File: rtl/mul_pipe.sv
`timescale 1ns/1ps

module mul_pipe (
   input  logic              clock,
   input  logic              reset,
   input  logic              issue_valid,
   input  mul_pkg::mul_op_t  issue_op,
   input  mul_pkg::xlen_t    rs1_data,
   input  mul_pkg::xlen_t    rs2_data,
   input  mul_pkg::rob_tag_t issue_rob_tag,
   input  mul_pkg::prf_tag_t issue_prd,
   input  logic              flush_valid,
   input  mul_pkg::rob_tag_t flush_rob_tag,
   output logic              pipe_valid,
   output mul_pkg::dword_t   pipe_product,
   output logic              pipe_high,
   output mul_pkg::rob_tag_t pipe_rob_tag,
   output mul_pkg::prf_tag_t pipe_prd
);

   logic              rs1_signed;
   logic              rs2_signed;
   logic              high_half;

   // index 0 is the issue side, index MUL_STAGES the last stage output
   logic              st_valid   [0:mul_pkg::MUL_STAGES];
   mul_pkg::dword_t   st_product [0:mul_pkg::MUL_STAGES];
   mul_pkg::dword_t   st_mcand   [0:mul_pkg::MUL_STAGES];
   mul_pkg::dword_t   st_mplier  [0:mul_pkg::MUL_STAGES];
   logic              st_high    [0:mul_pkg::MUL_STAGES];
   mul_pkg::rob_tag_t st_rob_tag [0:mul_pkg::MUL_STAGES];
   mul_pkg::prf_tag_t st_prd     [0:mul_pkg::MUL_STAGES];

   always_comb begin
      rs1_signed = 1'b0;
      rs2_signed = 1'b0;
      high_half  = 1'b1;
      case (issue_op)
         mul_pkg::MUL_OP_MUL:    high_half  = 1'b0;  // low half ignores sign
         mul_pkg::MUL_OP_MULH: begin
            rs1_signed = 1'b1;
            rs2_signed = 1'b1;
         end
         mul_pkg::MUL_OP_MULHSU: rs1_signed = 1'b1;
         default:                rs1_signed = 1'b0;  // mulhu
      endcase
   end

   assign st_valid[0]   = issue_valid;
   assign st_product[0] = '0;
   assign st_mcand[0]   = {{mul_pkg::XLEN{rs1_signed & rs1_data[mul_pkg::XLEN-1]}}, rs1_data};
   assign st_mplier[0]  = {{mul_pkg::XLEN{rs2_signed & rs2_data[mul_pkg::XLEN-1]}}, rs2_data};
   assign st_high[0]    = high_half;
   assign st_rob_tag[0] = issue_rob_tag;
   assign st_prd[0]     = issue_prd;

   for (genvar i = 0; i < mul_pkg::MUL_STAGES; i++) begin : g_stage
      mul_stage u_mul_stage (
         .clock         (clock),
         .reset         (reset),
         .in_valid      (st_valid[i]),
         .in_product    (st_product[i]),
         .in_mcand      (st_mcand[i]),
         .in_mplier     (st_mplier[i]),
         .in_high       (st_high[i]),
         .in_rob_tag    (st_rob_tag[i]),
         .in_prd        (st_prd[i]),
         .flush_valid   (flush_valid),
         .flush_rob_tag (flush_rob_tag),
         .out_valid     (st_valid[i+1]),
         .out_product   (st_product[i+1]),
         .out_mcand     (st_mcand[i+1]),
         .out_mplier    (st_mplier[i+1]),
         .out_high      (st_high[i+1]),
         .out_rob_tag   (st_rob_tag[i+1]),
         .out_prd       (st_prd[i+1])
      );
   end

   assign pipe_valid   = st_valid[mul_pkg::MUL_STAGES];
   assign pipe_product = st_product[mul_pkg::MUL_STAGES];
   assign pipe_high    = st_high[mul_pkg::MUL_STAGES];
   assign pipe_rob_tag = st_rob_tag[mul_pkg::MUL_STAGES];
   assign pipe_prd     = st_prd[mul_pkg::MUL_STAGES];

endmodule

// File: rtl/mul_stage.sv
`timescale 1ns/1ps

module mul_stage (
   input  logic              clock,
   input  logic              reset,
   input  logic              in_valid,
   input  mul_pkg::dword_t   in_product,
   input  mul_pkg::dword_t   in_mcand,
   input  mul_pkg::dword_t   in_mplier,
   input  logic              in_high,
   input  mul_pkg::rob_tag_t in_rob_tag,
   input  mul_pkg::prf_tag_t in_prd,
   input  logic              flush_valid,
   input  mul_pkg::rob_tag_t flush_rob_tag,
   output logic              out_valid,
   output mul_pkg::dword_t   out_product,
   output mul_pkg::dword_t   out_mcand,
   output mul_pkg::dword_t   out_mplier,
   output logic              out_high,
   output mul_pkg::rob_tag_t out_rob_tag,
   output mul_pkg::prf_tag_t out_prd
);

   mul_pkg::dword_t   sum_q;
   mul_pkg::dword_t   partial_q;
   mul_pkg::dword_t   mcand_q;
   mul_pkg::dword_t   mplier_q;
   logic              high_q;
   mul_pkg::rob_tag_t rob_tag_q;
   mul_pkg::prf_tag_t prd_q;
   logic              occupied_q;

   mul_pkg::dword_t   partial_d;
   logic              kill_in;

   // low slice of the multiplier times the full multiplicand
   assign partial_d = in_mplier[mul_pkg::STAGE_BITS-1:0] * in_mcand;

   // the entry is checked as it moves in, so the upstream entry's tag is
   // tested in the same cycle as every other occupied stage
   assign kill_in = flush_valid & mul_pkg::rob_killed(in_rob_tag, flush_rob_tag);

   always_ff @(posedge clock) begin
      if (in_valid) begin
         sum_q     <= in_product;
         partial_q <= partial_d;
         mcand_q   <= in_mcand << mul_pkg::STAGE_BITS;
         mplier_q  <= in_mplier >> mul_pkg::STAGE_BITS;
         high_q    <= in_high;
         rob_tag_q <= in_rob_tag;
         prd_q     <= in_prd;
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         occupied_q <= 1'b0;
      end else begin
         occupied_q <= in_valid & ~kill_in;  // follows upstream, no stall
      end
   end

   assign out_valid   = occupied_q;
   assign out_product = sum_q + partial_q;
   assign out_mcand   = mcand_q;
   assign out_mplier  = mplier_q;
   assign out_high    = high_q;
   assign out_rob_tag = rob_tag_q;
   assign out_prd     = prd_q;

endmodule

// File: rtl/mul_pkg.sv
package mul_pkg;

   localparam int XLEN         = 32;
   localparam int MUL_STAGES   = 4;
   localparam int STAGE_BITS   = (2 * XLEN) / MUL_STAGES;  // multiplier bits per stage
   localparam int ROB_IDX_BITS = 4;
   localparam int PRF_BITS     = 6;

   typedef logic [XLEN-1:0]       xlen_t;
   typedef logic [2*XLEN-1:0]     dword_t;
   typedef logic [ROB_IDX_BITS:0] rob_tag_t;  // wrap bit on top
   typedef logic [PRF_BITS-1:0]   prf_tag_t;
   typedef logic [1:0]            mul_op_t;

   localparam mul_op_t MUL_OP_MUL    = 2'd0;
   localparam mul_op_t MUL_OP_MULH   = 2'd1;
   localparam mul_op_t MUL_OP_MULHSU = 2'd2;
   localparam mul_op_t MUL_OP_MULHU  = 2'd3;

   // kill rule against the flush boundary
   // same wrap: index below flush index dies, wrap differs: the rule inverts
   function automatic logic rob_killed(input rob_tag_t tag, input rob_tag_t flush_tag);
      logic wrap_diff;
      logic idx_below;
      wrap_diff = tag[ROB_IDX_BITS] ^ flush_tag[ROB_IDX_BITS];
      idx_below = tag[ROB_IDX_BITS-1:0] < flush_tag[ROB_IDX_BITS-1:0];
      return wrap_diff ^ idx_below;
   endfunction

endpackage
